//--- common/spu32_pkg.sv
package spu32_pkg;

    localparam int xlen = 32;
    // bytes per instruction, also the sequential pc step
    localparam int instr_len = 4;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // major opcodes as found in instr[6:2]
    typedef enum logic [4:0] {
        opc_load     = 5'b00000,
        opc_misc_mem = 5'b00011,
        opc_op_imm   = 5'b00100,
        opc_auipc    = 5'b00101,
        opc_store    = 5'b01000,
        opc_op       = 5'b01100,
        opc_lui      = 5'b01101,
        opc_branch   = 5'b11000,
        opc_jalr     = 5'b11001,
        opc_jal      = 5'b11011
    } opcode_t;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // one bit per branch condition
    typedef logic [5:0] branch_mask_t;
    localparam int br_eq  = 0;
    localparam int br_ne  = 1;
    localparam int br_lt  = 2;
    localparam int br_ge  = 3;
    localparam int br_ltu = 4;
    localparam int br_geu = 5;

    typedef enum logic {bus_read = 1'b0, bus_write = 1'b1} bus_op_t;

    // operand and write-back selects of the control unit
    typedef enum logic {a_reg, a_pc} a_sel_t;
    typedef enum logic [1:0] {b_reg, b_imm, b_len} b_sel_t;
    typedef enum logic [1:0] {wb_alu, wb_bus, wb_imm, wb_link} wb_sel_t;

endpackage

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  logic              en,
    input  spu32_pkg::alu_op_t op,
    input  spu32_pkg::word_t  a,
    input  spu32_pkg::word_t  b,
    output spu32_pkg::word_t  result,
    output logic              lt,
    output logic              ltu,
    output logic              eq
);
    import spu32_pkg::*;

    word_t      res;
    logic       lt_c;
    logic       ltu_c;
    logic [4:0] shamt;

    assign lt_c  = $signed(a) < $signed(b);
    assign ltu_c = a < b;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_sll:  res = a << shamt;
            alu_slt:  res = word_t'(lt_c);
            alu_sltu: res = word_t'(ltu_c);
            alu_xor:  res = a ^ b;
            alu_srl:  res = a >> shamt;
            alu_sra:  res = word_t'($signed(a) >>> shamt);
            alu_or:   res = a | b;
            alu_and:  res = a & b;
            default:  res = a + b;
        endcase
    end

    // result and flags hold until the next enable
    always_ff @(posedge clk) begin
        if (en) begin
            result <= res;
            lt     <= lt_c;
            ltu    <= ltu_c;
            eq     <= (a == b);
        end
    end

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                    clk,
    input  logic                    en,
    input  spu32_pkg::word_t        instr,
    output spu32_pkg::reg_addr_t    rs1,
    output spu32_pkg::reg_addr_t    rs2,
    output spu32_pkg::reg_addr_t    rd,
    output spu32_pkg::word_t        imm,
    output spu32_pkg::opcode_t      opcode,
    output spu32_pkg::alu_op_t      alu_op,
    output spu32_pkg::branch_mask_t branch_mask
);
    import spu32_pkg::*;

    logic [2:0]   funct3;
    opcode_t      opc_next;
    word_t        imm_next;
    logic         alt;
    branch_mask_t mask_next;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_b;
    word_t        imm_u;
    word_t        imm_j;

    assign funct3 = instr[14:12];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (instr[6:2])
            opc_load, opc_misc_mem, opc_op_imm, opc_auipc, opc_store,
            opc_op, opc_lui, opc_branch, opc_jalr, opc_jal:
                opc_next = opcode_t'(instr[6:2]);
            // anything else retires as a nop
            default: opc_next = opc_misc_mem;
        endcase
    end

    always_comb begin
        case (opc_next)
            opc_store:          imm_next = imm_s;
            opc_branch:         imm_next = imm_b;
            opc_lui, opc_auipc: imm_next = imm_u;
            opc_jal:            imm_next = imm_j;
            default:            imm_next = imm_i;
        endcase
    end

    // sub and sra only in the register-register form
    assign alt = (opc_next == opc_op) && instr[30]
        && (funct3 == 3'b000 || funct3 == 3'b101);

    always_comb begin
        mask_next = '0;
        case (funct3)
            3'b000:  mask_next[br_eq]  = 1'b1;
            3'b001:  mask_next[br_ne]  = 1'b1;
            3'b100:  mask_next[br_lt]  = 1'b1;
            3'b101:  mask_next[br_ge]  = 1'b1;
            3'b110:  mask_next[br_ltu] = 1'b1;
            3'b111:  mask_next[br_geu] = 1'b1;
            default: mask_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rs1         <= instr[19:15];
            rs2         <= instr[24:20];
            rd          <= instr[11:7];
            imm         <= imm_next;
            opcode      <= opc_next;
            alu_op      <= alu_op_t'({alt, funct3});
            branch_mask <= mask_next;
        end
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 re,
    input  logic                 we,
    input  spu32_pkg::reg_addr_t rs1,
    input  spu32_pkg::reg_addr_t rs2,
    input  spu32_pkg::reg_addr_t rd,
    input  spu32_pkg::word_t     wdata,
    output spu32_pkg::word_t     rdata1,
    output spu32_pkg::word_t     rdata2
);
    import spu32_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
        // x0 always reads as zero
        if (re) begin
            rdata1 <= (rs1 == '0) ? '0 : regs[rs1];
            rdata2 <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

//--- rtl/control_fsm.sv
`timescale 1ns/1ps

module control_fsm #(
    parameter spu32_pkg::word_t reset_vector = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    bus_ack,
    input  spu32_pkg::word_t        bus_rdata,
    input  spu32_pkg::reg_addr_t    rd,
    input  spu32_pkg::word_t        imm,
    input  spu32_pkg::opcode_t      opcode,
    input  spu32_pkg::alu_op_t      alu_op,
    input  spu32_pkg::branch_mask_t branch_mask,
    input  spu32_pkg::word_t        rdata1,
    input  spu32_pkg::word_t        rdata2,
    input  spu32_pkg::word_t        alu_result,
    input  logic                    alu_lt,
    input  logic                    alu_ltu,
    input  logic                    alu_eq,
    output logic                    bus_req,
    output spu32_pkg::bus_op_t      bus_op,
    output spu32_pkg::word_t        bus_addr,
    output spu32_pkg::word_t        bus_wdata,
    output logic                    dec_en,
    output logic                    reg_re,
    output logic                    reg_we,
    output spu32_pkg::word_t        reg_wdata,
    output spu32_pkg::reg_addr_t    rd_sel,
    output logic                    alu_en,
    output spu32_pkg::alu_op_t      alu_op_sel,
    output spu32_pkg::word_t        alu_a,
    output spu32_pkg::word_t        alu_b
);
    import spu32_pkg::*;

    typedef enum logic [2:0] {
        st_fetch, st_fetch_wait, st_decode, st_exec, st_mem, st_branch2, st_wb
    } state_t;

    state_t  state;
    word_t   pc;
    word_t   pc_next;
    logic    take_jump;
    logic    branch_taken;
    logic    writes_rd;
    a_sel_t  a_sel;
    b_sel_t  b_sel;
    wb_sel_t wb_sel;

    // flags ordered as the mask bits, eq in bit 0
    assign branch_taken = |(branch_mask & {!alu_ltu, alu_ltu, !alu_lt, alu_lt, !alu_eq, alu_eq});

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_fetch;
            pc        <= reset_vector;
            bus_req   <= 1'b0;
            take_jump <= 1'b0;
        end else begin
            case (state)
                st_fetch: if (!bus_ack) begin
                    bus_req <= 1'b1;
                    state   <= st_fetch_wait;
                end
                st_fetch_wait: if (bus_ack) begin
                    bus_req <= 1'b0;
                    state   <= st_decode;
                end
                st_decode: state <= st_exec;
                st_exec: begin
                    take_jump <= (opcode == opc_jal) || (opcode == opc_jalr);
                    case (opcode)
                        opc_load, opc_store: state <= st_mem;
                        opc_branch:          state <= st_branch2;
                        default:             state <= st_wb;
                    endcase
                end
                st_mem: begin
                    // raise req only once the previous ack is gone
                    if (!bus_req && !bus_ack) begin
                        bus_req <= 1'b1;
                    end else if (bus_req && bus_ack) begin
                        bus_req <= 1'b0;
                        state   <= st_wb;
                    end
                end
                st_branch2: begin
                    take_jump <= branch_taken;
                    state     <= st_wb;
                end
                st_wb: begin
                    pc    <= take_jump ? {alu_result[31:1], 1'b0} : pc_next;
                    state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // pc + instr_len from the decode cycle is still on the alu output here
    always_ff @(posedge clk) begin
        if (state == st_exec) begin
            pc_next <= alu_result;
        end
    end

    always_comb begin
        alu_en     = 1'b0;
        alu_op_sel = alu_add;
        a_sel      = a_reg;
        b_sel      = b_reg;
        case (state)
            st_decode: begin
                alu_en = 1'b1;
                a_sel  = a_pc;
                b_sel  = b_len;
            end
            st_exec: begin
                alu_en = 1'b1;
                case (opcode)
                    opc_op: alu_op_sel = alu_op;
                    opc_op_imm: begin
                        alu_op_sel = alu_op;
                        b_sel      = b_imm;
                    end
                    opc_jal, opc_auipc: begin
                        a_sel = a_pc;
                        b_sel = b_imm;
                    end
                    opc_jalr, opc_load, opc_store: b_sel = b_imm;
                    // branches compare rs1 against rs2
                    default: b_sel = b_reg;
                endcase
            end
            st_branch2: begin
                alu_en = 1'b1;
                a_sel  = a_pc;
                b_sel  = b_imm;
            end
            default: alu_en = 1'b0;
        endcase
    end

    assign alu_a = (a_sel == a_pc) ? pc : rdata1;

    always_comb begin
        case (b_sel)
            b_reg:   alu_b = rdata2;
            b_imm:   alu_b = imm;
            default: alu_b = word_t'(instr_len);
        endcase
    end

    always_comb begin
        writes_rd = 1'b1;
        case (opcode)
            opc_load:                      wb_sel = wb_bus;
            opc_lui:                       wb_sel = wb_imm;
            opc_jal, opc_jalr:             wb_sel = wb_link;
            opc_op, opc_op_imm, opc_auipc: wb_sel = wb_alu;
            default: begin
                wb_sel    = wb_alu;
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (wb_sel)
            wb_bus:  reg_wdata = bus_rdata;
            wb_imm:  reg_wdata = imm;
            wb_link: reg_wdata = pc_next;
            default: reg_wdata = alu_result;
        endcase
    end

    assign reg_we = (state == st_wb) && writes_rd;
    // idle write port points at x0
    assign rd_sel = reg_we ? rd : '0;

    assign dec_en    = (state == st_fetch_wait) && bus_ack;
    assign reg_re    = (state == st_decode);
    assign bus_addr  = (state == st_mem) ? alu_result : pc;
    assign bus_op    = (state == st_mem && opcode == opc_store) ? bus_write : bus_read;
    assign bus_wdata = rdata2;

endmodule

//--- rtl/bus_wb8.sv
`timescale 1ns/1ps

module bus_wb8 (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  spu32_pkg::bus_op_t op,
    input  spu32_pkg::word_t   addr,
    input  spu32_pkg::word_t   wdata,
    input  logic               ack,
    input  logic               stall,
    input  logic [7:0]         dat_i,
    output logic               bus_ack,
    output spu32_pkg::word_t   rdata,
    output spu32_pkg::word_t   adr,
    output logic [7:0]         dat_o,
    output logic               cyc,
    output logic               stb,
    output logic               we
);
    import spu32_pkg::*;

    typedef enum logic [1:0] {st_idle, st_strobe, st_wait, st_done} state_t;

    state_t     state;
    logic [1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            cnt     <= 2'd0;
            cyc     <= 1'b0;
            stb     <= 1'b0;
            bus_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: if (req) begin
                    cnt   <= 2'd0;
                    cyc   <= 1'b1;
                    stb   <= 1'b1;
                    state <= st_strobe;
                end
                // hold stb until the slave takes the byte
                st_strobe: if (!stall) begin
                    stb   <= 1'b0;
                    state <= st_wait;
                end
                st_wait: if (ack) begin
                    if (cnt == 2'd3) begin
                        cyc     <= 1'b0;
                        bus_ack <= 1'b1;
                        state   <= st_done;
                    end else begin
                        cnt   <= cnt + 2'd1;
                        stb   <= 1'b1;
                        state <= st_strobe;
                    end
                end
                st_done: if (!req) begin
                    bus_ack <= 1'b0;
                    state   <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // little endian, byte i lands in rdata[8*i +: 8]
    always_ff @(posedge clk) begin
        if (state == st_wait && ack) begin
            rdata[cnt*8 +: 8] <= dat_i;
        end
    end

    assign adr   = addr + xlen'(cnt);
    assign dat_o = wdata[cnt*8 +: 8];
    assign we    = cyc && (op == bus_write);

endmodule

//--- rtl/spu32_cpu.sv
`timescale 1ns/1ps

module spu32_cpu #(
    parameter spu32_pkg::word_t reset_vector = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ack,
    input  logic                 stall,
    input  logic [7:0]           dat_i,
    output spu32_pkg::word_t     adr,
    output logic [7:0]           dat_o,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we
);
    import spu32_pkg::*;

    // control to bus unit
    logic         bus_req;
    bus_op_t      bus_op;
    word_t        bus_addr;
    word_t        bus_wdata;
    logic         bus_ack;
    word_t        bus_rdata;

    // decoder fields
    logic         dec_en;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        imm;
    opcode_t      opcode;
    alu_op_t      dec_alu_op;
    branch_mask_t branch_mask;

    // register file
    logic         reg_re;
    logic         reg_we;
    word_t        reg_wdata;
    reg_addr_t    rd_sel;
    word_t        rdata1;
    word_t        rdata2;

    // alu
    logic         alu_en;
    alu_op_t      alu_op_sel;
    word_t        alu_a;
    word_t        alu_b;
    word_t        alu_result;
    logic         alu_lt;
    logic         alu_ltu;
    logic         alu_eq;

    control_fsm #(
        .reset_vector(reset_vector)
    ) u_control (
        .clk         (clk),
        .reset       (reset),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata),
        .rd          (rd),
        .imm         (imm),
        .opcode      (opcode),
        .alu_op      (dec_alu_op),
        .branch_mask (branch_mask),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .alu_result  (alu_result),
        .alu_lt      (alu_lt),
        .alu_ltu     (alu_ltu),
        .alu_eq      (alu_eq),
        .bus_req     (bus_req),
        .bus_op      (bus_op),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .dec_en      (dec_en),
        .reg_re      (reg_re),
        .reg_we      (reg_we),
        .reg_wdata   (reg_wdata),
        .rd_sel      (rd_sel),
        .alu_en      (alu_en),
        .alu_op_sel  (alu_op_sel),
        .alu_a       (alu_a),
        .alu_b       (alu_b)
    );

    alu u_alu (
        .clk    (clk),
        .en     (alu_en),
        .op     (alu_op_sel),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .lt     (alu_lt),
        .ltu    (alu_ltu),
        .eq     (alu_eq)
    );

    // instruction word comes straight from the fetch read data
    decoder u_decoder (
        .clk         (clk),
        .en          (dec_en),
        .instr       (bus_rdata),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .opcode      (opcode),
        .alu_op      (dec_alu_op),
        .branch_mask (branch_mask)
    );

    register_file u_register_file (
        .clk    (clk),
        .re     (reg_re),
        .we     (reg_we),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd_sel),
        .wdata  (reg_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    bus_wb8 u_bus (
        .clk     (clk),
        .reset   (reset),
        .req     (bus_req),
        .op      (bus_op),
        .addr    (bus_addr),
        .wdata   (bus_wdata),
        .ack     (ack),
        .stall   (stall),
        .dat_i   (dat_i),
        .bus_ack (bus_ack),
        .rdata   (bus_rdata),
        .adr     (adr),
        .dat_o   (dat_o),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- bench/spu32_checker.sv
`timescale 1ns/1ps

module spu32_checker (
    input logic             clk,
    input logic             reset,
    input logic             cyc,
    input logic             stb,
    input logic             ack,
    input logic             stall,
    input spu32_pkg::word_t adr
);
    import spu32_pkg::*;

    int         fail_count = 0;
    logic [1:0] acks;
    word_t      last_adr;

    // acks seen so far in the current word transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            acks <= 2'd0;
        end else if (cyc && ack) begin
            acks <= acks + 2'd1;
        end
    end

    // address of the last accepted byte
    always_ff @(posedge clk) begin
        if (stb && !stall) begin
            last_adr <= adr;
        end
    end

    assert property (@(posedge clk) reset |=> (!cyc && !stb))
        else begin
            $error("cyc or stb high right after a reset cycle");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else begin
            $error("stb high while cyc is low");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset)
        (stb && !stall && acks != 2'd0) |-> (adr == last_adr + 32'd1))
        else begin
            $error("byte address did not step by one within a transfer");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset)
        (cyc && !(ack && acks == 2'd3)) |=> cyc)
        else begin
            $error("cyc dropped before the fourth ack");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset)
        (cyc && ack && acks == 2'd3) |=> !cyc)
        else begin
            $error("cyc still high after the fourth ack");
            fail_count++;
        end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // about 50 instructions, up to 100 cycles each under stall and ack delay, 4x margin
    localparam int timeout_cycles = 50 * 100 * 4;

    logic        clk;
    logic        reset;
    logic        ack = 1'b0;
    logic        stall = 1'b0;
    logic [7:0]  dat_i = 8'h00;
    logic [31:0] adr;
    logic [7:0]  dat_o;
    logic        cyc;
    logic        stb;
    logic        we;

    logic [7:0]  mem [1024];
    logic [31:0] exp_word [256];
    logic        exp_valid [256];
    logic [3:0]  exp_seen [256];
    logic [31:0] lfsr_state = 32'h4021_1754;
    logic [31:0] fill_addr;
    logic [31:0] req_adr;
    logic        pending;
    logic [3:0]  delay;
    logic [3:0]  rnd;
    logic        seen_stb;
    logic        marker_done;
    int          cycles;

    tb_clock #(
        .half_period (20),
        .reset_cycles(16)
    ) u_clock (
        .clk  (clk),
        .reset(reset)
    );

    spu32_cpu #(
        .reset_vector(32'h0)
    ) u_spu32_cpu (
        .clk  (clk),
        .reset(reset),
        .ack  (ack),
        .stall(stall),
        .dat_i(dat_i),
        .adr  (adr),
        .dat_o(dat_o),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we)
    );

    bind spu32_cpu spu32_checker u_checker (
        .clk  (clk),
        .reset(reset),
        .cyc  (cyc),
        .stb  (stb),
        .ack  (ack),
        .stall(stall),
        .adr  (adr)
    );

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [3:0] bits);
        bits = 4'h0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[2:0], lfsr_state[0]};
        end
    endtask

    task automatic put_word(input logic [31:0] addr, input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            mem[addr[9:0] + 10'(i)] = w[8*i +: 8];
        end
    endtask

    task automatic emit_instr(input logic [31:0] w);
        put_word(fill_addr, w);
        fill_addr = fill_addr + 32'd4;
    endtask

    task automatic expect_word(input logic [31:0] addr, input logic [31:0] w);
        exp_word[addr[9:2]]  = w;
        exp_valid[addr[9:2]] = 1'b1;
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // word store only
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'h00;
        end
        for (int i = 0; i < 256; i++) begin
            exp_word[i]  = 32'h0;
            exp_valid[i] = 1'b0;
            exp_seen[i]  = 4'h0;
        end
        fill_addr = 32'h0;
        emit_instr(enc_i(12'd100, 5'd0, 3'b000, 5'd1, opc_op_imm));
        emit_instr(enc_i(-12'd7, 5'd0, 3'b000, 5'd2, opc_op_imm));
        emit_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit_instr(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
        emit_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        emit_instr(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd6));
        emit_instr(enc_u(20'hABCDE, 5'd7, opc_lui));
        emit_instr(enc_u(20'h00001, 5'd8, opc_auipc));
        // poison value in x17
        emit_instr(enc_u(20'hDEAD0, 5'd17, opc_lui));
        emit_instr(enc_s(12'h200, 5'd3, 5'd0));
        emit_instr(enc_s(12'h204, 5'd4, 5'd0));
        emit_instr(enc_s(12'h208, 5'd5, 5'd0));
        emit_instr(enc_s(12'h20C, 5'd6, 5'd0));
        emit_instr(enc_s(12'h210, 5'd7, 5'd0));
        emit_instr(enc_s(12'h214, 5'd8, 5'd0));
        // countdown loop at 0x44
        emit_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd9, opc_op_imm));
        emit_instr(enc_i(12'd0, 5'd0, 3'b000, 5'd10, opc_op_imm));
        emit_instr(enc_i(12'd1, 5'd10, 3'b000, 5'd10, opc_op_imm));
        emit_instr(enc_i(-12'd1, 5'd9, 3'b000, 5'd9, opc_op_imm));
        emit_instr(enc_b(-13'd8, 5'd0, 5'd9, 3'b001));
        emit_instr(enc_s(12'h218, 5'd10, 5'd0));
        emit_instr(enc_b(13'd8, 5'd0, 5'd0, 3'b000));
        emit_instr(enc_s(12'h3F0, 5'd17, 5'd0));
        // jal at 0x5c, link 0x60
        emit_instr(enc_j(21'd8, 5'd12));
        emit_instr(enc_s(12'h3F0, 5'd17, 5'd0));
        emit_instr(enc_i(12'h070, 5'd0, 3'b000, 5'd13, opc_op_imm));
        // jalr at 0x68 to 0x74, link 0x6c
        emit_instr(enc_i(12'd4, 5'd13, 3'b000, 5'd14, opc_jalr));
        emit_instr(enc_s(12'h3F0, 5'd17, 5'd0));
        emit_instr(enc_s(12'h3F0, 5'd17, 5'd0));
        emit_instr(enc_s(12'h21C, 5'd12, 5'd0));
        emit_instr(enc_s(12'h220, 5'd14, 5'd0));
        emit_instr(enc_i(12'h1F0, 5'd0, 3'b010, 5'd15, opc_load));
        emit_instr(enc_i(12'd1, 5'd15, 3'b000, 5'd15, opc_op_imm));
        emit_instr(enc_s(12'h224, 5'd15, 5'd0));
        emit_instr(enc_u(20'h600D1, 5'd16, opc_lui));
        emit_instr(enc_i(12'h05A, 5'd16, 3'b000, 5'd16, opc_op_imm));
        emit_instr(enc_s(12'h3FC, 5'd16, 5'd0));
        emit_instr(enc_j(21'd0, 5'd0));
        put_word(32'h1F0, 32'h1234_5678);

        expect_word(32'h200, 32'd100 + 32'hFFFF_FFF9);
        expect_word(32'h204, 32'hFFFF_FFF9 - 32'd100);
        expect_word(32'h208, 32'd100 ^ 32'hFFFF_FFF9);
        // -7 < 100 signed
        expect_word(32'h20C, 32'd1);
        expect_word(32'h210, 32'hABCD_E000);
        expect_word(32'h214, 32'h0000_001C + 32'h0000_1000);
        expect_word(32'h218, 32'd5);
        expect_word(32'h21C, 32'h0000_005C + 32'd4);
        expect_word(32'h220, 32'h0000_0068 + 32'd4);
        expect_word(32'h224, 32'h1234_5678 + 32'd1);
        expect_word(32'h3FC, 32'h600D_1000 + 32'h0000_005A);
    end

    task automatic finish_run();
        int missing;
        missing = 0;
        for (int w = 0; w < 256; w++) begin
            if (exp_valid[w] && exp_seen[w] != 4'hF) begin
                missing++;
            end
        end
        if (missing != 0) begin
            stop_on_failure($sformatf("%0d expected store words were never written", missing));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    endtask

    // byte taken by the slave on this edge
    task automatic accept_byte();
        logic [7:0] want;
        assert (adr < 32'd1024)
            else stop_on_failure($sformatf("bus address %h outside the memory", adr));
        draw_bits(2, delay);
        req_adr = adr;
        pending = 1'b1;
        if (we) begin
            want = exp_word[adr[9:2]][{adr[1:0], 3'b000} +: 8];
            assert (adr[9:2] != 8'hFC)
                else stop_on_failure("poison store executed, a branch or jump went wrong");
            assert (exp_valid[adr[9:2]])
                else stop_on_failure($sformatf("unexpected store to %h", adr));
            assert (dat_o == want)
                else stop_on_failure($sformatf(
                    "MISMATCH dat_o at adr %h: got %h, expected %h", adr, dat_o, want));
            mem[adr[9:0]] = dat_o;
            exp_seen[adr[9:2]][adr[1:0]] = 1'b1;
            if (adr == 32'h3FF) begin
                marker_done = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            stall       <= 1'b0;
            ack         <= 1'b0;
            pending     = 1'b0;
            seen_stb    = 1'b0;
            marker_done = 1'b0;
            cycles      = 0;
        end else begin
            cycles = cycles + 1;
            assert (cycles < timeout_cycles)
                else stop_on_failure("timeout, the end marker was never stored");
            assert (u_spu32_cpu.u_checker.fail_count == 0)
                else stop_on_failure("a bus protocol assertion failed");
            if (!seen_stb) begin
                assert (cyc == stb)
                    else stop_on_failure("cyc high before the first strobe");
                if (stb) begin
                    assert (adr == 32'h0)
                        else stop_on_failure($sformatf(
                            "MISMATCH adr on first strobe: got %h, expected %h", adr, 32'h0));
                    seen_stb = 1'b1;
                end
            end
            draw_bits(2, rnd);
            stall <= &rnd[1:0];
            ack   <= 1'b0;
            if (stb && !stall) begin
                accept_byte();
            end
            // ack after a random delay of 0 to 3 cycles
            if (pending) begin
                if (delay == 4'd0) begin
                    ack     <= 1'b1;
                    dat_i   <= mem[req_adr[9:0]];
                    pending = 1'b0;
                end else begin
                    delay = delay - 4'd1;
                end
            end
            if (marker_done) begin
                finish_run();
            end
        end
    end

endmodule

//--- filelist.f
common/spu32_pkg.sv
rtl/alu.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/control_fsm.sv
rtl/bus_wb8.sv
rtl/spu32_cpu.sv
bench/tb_clock.sv
bench/spu32_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f filelist.f -o tb_sim &&
{ ./obj_dir/tb_sim > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log; }
cat sim.log &&
! grep -q "TB FAILED" sim.log &&
grep -q "TB PASSED" sim.log
